// ==== verilog.f ====
hw/uart_pkg.sv
hw/uart_tx_queue.sv
hw/uart_tx.sv
hw/uart_rx.sv
hw/uart_core.sv
testbench/uart_core_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
rm -rf obj_dir sim.log
verilator --binary --timing --assert --timescale 1ns/10ps \
    --top-module uart_core_tb -f verilog.f -o uart_core_sim \
    || { echo "verilator build failed"; exit 1; }
./obj_dir/uart_core_sim > sim.log 2>&1 \
    || echo "simulator exited with an error"
cat sim.log
grep -q "Test OK" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// ==== testbench/uart_core_tb.sv ====
`timescale 1ns/10ps

module uart_core_tb;

    localparam int timeout_cycles = 4000;
    localparam int num_entries    = 9;
    localparam int mode_loop      = 0;  // through the queue, tx_pin looped back
    localparam int mode_bad_stop  = 1;  // bit-banged frame with a low stop bit
    localparam int mode_hold      = 2;  // received, left unacknowledged
    localparam int mode_lost      = 3;  // sent while the previous offer is held

    logic                        clk;
    logic                        rst_n;
    logic [uart_pkg::baud_w-1:0] baud_div;
    logic                        wr_req;
    logic [uart_pkg::data_w-1:0] wr_data;
    logic                        wr_ack;
    logic                        rx_pin;
    logic                        rx_req;
    logic [uart_pkg::data_w-1:0] rx_data;
    logic                        rx_frame_err;
    logic                        rx_overrun;
    logic                        rx_ack;
    logic                        tx_pin;
    logic                        tx_busy;
    logic                        inject_sel;  // high selects the bit-banged line
    logic                        inject_pin;

    logic [7:0]  tab_byte [num_entries];
    logic [15:0] tab_div  [num_entries];
    int          tab_mode [num_entries];
    logic [7:0]  tab_exp  [num_entries];
    logic        tab_ferr [num_entries];
    logic        tab_ovr  [num_entries];
    logic [7:0]  bp_bytes [6];

    int          errors;
    int          tests_run;
    int          tests_failed;
    logic [31:0] rand_state;

    uart_core #(
        .tx_queue_depth (4)
    ) uart_core_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .baud_div     (baud_div),
        .wr_req       (wr_req),
        .wr_data      (wr_data),
        .wr_ack       (wr_ack),
        .rx_pin       (rx_pin),
        .rx_req       (rx_req),
        .rx_data      (rx_data),
        .rx_frame_err (rx_frame_err),
        .rx_overrun   (rx_overrun),
        .rx_ack       (rx_ack),
        .tx_pin       (tx_pin),
        .tx_busy      (tx_busy)
    );

    assign rx_pin = inject_sel ? inject_pin : tx_pin;

    always #20 clk = ~clk;

    function automatic logic [31:0] next_random(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic add_entry(input int idx, input logic [7:0] b, input logic [15:0] d,
                             input int m, input logic [7:0] exp_data, input logic f,
                             input logic o);
        tab_byte[idx] = b;
        tab_div[idx]  = d;
        tab_mode[idx] = m;
        tab_exp[idx]  = exp_data;
        tab_ferr[idx] = f;
        tab_ovr[idx]  = o;
    endtask

    task automatic load_table();
        add_entry(0, 8'h55, 16'd3,  mode_loop,     8'h55, 1'b0, 1'b0);
        add_entry(1, 8'ha3, 16'd7,  mode_loop,     8'ha3, 1'b0, 1'b0);
        add_entry(2, 8'h0f, 16'd12, mode_loop,     8'h0f, 1'b0, 1'b0);
        add_entry(3, 8'hc6, 16'd7,  mode_bad_stop, 8'hc6, 1'b1, 1'b0);
        add_entry(4, 8'h3c, 16'd3,  mode_loop,     8'h3c, 1'b0, 1'b0);
        add_entry(5, 8'h81, 16'd3,  mode_hold,     8'h81, 1'b0, 1'b0);
        add_entry(6, 8'h7e, 16'd3,  mode_lost,     8'h81, 1'b0, 1'b0); // held offer unchanged
        add_entry(7, 8'h96, 16'd3,  mode_loop,     8'h96, 1'b0, 1'b1);
        add_entry(8, 8'h42, 16'd12, mode_loop,     8'h42, 1'b0, 1'b0);
    endtask

    task automatic timed_out(input string what);
        $display("timeout while waiting for %s", what);
        errors++;
    endtask

    task automatic compare_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Fail %s: got 0x%0h expected 0x%0h", name, got, exp);
            errors++;
        end
    endtask

    task automatic finish_test(input string name, input int errors_before);
        tests_run++;
        if (errors == errors_before) begin
            $display("test %0d %s: passed", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: failed", tests_run, name);
        end
    endtask

    // four-phase write, notes whether tx_busy was low before the ack
    task automatic write_byte(input logic [7:0] data, output logic busy_low_seen);
        int n;
        busy_low_seen = 1'b0;
        wr_data = data;
        wr_req  = 1'b1;
        for (n = 0; n < timeout_cycles && !wr_ack; n++) begin
            @(negedge clk);
            if (!tx_busy && !wr_ack) begin
                busy_low_seen = 1'b1;
            end
        end
        if (!wr_ack) begin
            timed_out("wr_ack to rise");
        end
        wr_req = 1'b0;
        for (n = 0; n < timeout_cycles && wr_ack; n++) begin
            @(negedge clk);
        end
        if (wr_ack) begin
            timed_out("wr_ack to fall");
        end
    endtask

    task automatic wait_tx_idle();
        int n;
        for (n = 0; n < timeout_cycles && tx_busy; n++) begin
            @(negedge clk);
        end
        if (tx_busy) begin
            timed_out("tx_busy to fall");
        end
    endtask

    task automatic wait_offer();
        int n;
        for (n = 0; n < timeout_cycles && !rx_req; n++) begin
            @(negedge clk);
        end
        if (!rx_req) begin
            timed_out("rx_req to rise");
        end
    endtask

    task automatic check_offer(input logic [7:0] exp_data, input logic exp_ferr,
                               input logic exp_ovr);
        if (rx_req) begin
            if (rx_data !== exp_data) begin
                $display("Fail rx_data: got 0x%02h expected 0x%02h", rx_data, exp_data);
                errors++;
            end
            if (rx_frame_err !== exp_ferr) begin
                $display("Fail rx_frame_err: got 0x%0h expected 0x%0h", rx_frame_err, exp_ferr);
                errors++;
            end
            if (rx_overrun !== exp_ovr) begin
                $display("Fail rx_overrun: got 0x%0h expected 0x%0h", rx_overrun, exp_ovr);
                errors++;
            end
        end
    endtask

    task automatic ack_offer();
        int n;
        rx_ack = 1'b1;
        for (n = 0; n < timeout_cycles && rx_req; n++) begin
            @(negedge clk);
        end
        if (rx_req) begin
            timed_out("rx_req to fall");
        end
        rx_ack = 1'b0;
        @(negedge clk);
    endtask

    // every cycle of the ten bits must match, so each bit is div + 1 wide
    // tx_busy falls right after the stop bit, which fixes its width too
    task automatic check_tx_frame(input logic [7:0] data, input logic [15:0] div);
        int         n;
        int         b;
        int         c;
        int         bad;
        logic [9:0] frame;
        frame = {1'b1, data, 1'b0};  // stop, data, start
        bad   = 0;
        for (n = 0; n < timeout_cycles && tx_pin; n++) begin
            @(negedge clk);
        end
        if (tx_pin) begin
            timed_out("the start bit on tx_pin");
        end else begin
            for (b = 0; b < 10; b++) begin
                for (c = 0; c <= 32'(div); c++) begin
                    if (tx_pin !== frame[b] || tx_busy !== 1'b1) begin
                        bad++;
                    end
                    @(negedge clk);
                end
            end
            if (tx_busy !== 1'b0) begin
                bad++;
            end
            if (bad != 0) begin
                $display("tx_pin or tx_busy timing wrong in %0d cycles of the frame", bad);
                errors++;
            end
        end
    endtask

    task automatic inject_frame(input logic [7:0] data, input logic [15:0] div,
                                input logic stop);
        int         b;
        logic [9:0] frame;
        frame      = {stop, data, 1'b0};
        inject_sel = 1'b1;
        for (b = 0; b < 10; b++) begin
            inject_pin = frame[b];
            repeat (32'(div) + 1) @(negedge clk);
        end
        inject_pin = 1'b1;
        inject_sel = 1'b0;  // both sources high here
    endtask

    initial begin
        int   i;
        int   e0;
        logic busy_seen;
        clk          = 1'b0;
        rst_n        = 1'b0;
        baud_div     = 16'd3;
        wr_req       = 1'b0;
        wr_data      = 8'h00;
        rx_ack       = 1'b0;
        inject_sel   = 1'b0;
        inject_pin   = 1'b1;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        rand_state   = 32'hd5350bb2;
        load_table();
        repeat (2) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);

        e0 = errors;
        compare_bit("tx_pin", tx_pin, 1'b1);
        compare_bit("wr_ack", wr_ack, 1'b0);
        compare_bit("rx_req", rx_req, 1'b0);
        compare_bit("tx_busy", tx_busy, 1'b0);
        compare_bit("rx_frame_err", rx_frame_err, 1'b0);
        compare_bit("rx_overrun", rx_overrun, 1'b0);
        finish_test("reset state", e0);

        for (i = 0; i < num_entries; i++) begin
            e0 = errors;
            wait_tx_idle();
            baud_div = tab_div[i];
            case (tab_mode[i])
                mode_loop: begin
                    fork
                        write_byte(tab_byte[i], busy_seen);
                        check_tx_frame(tab_byte[i], tab_div[i]);
                    join
                    wait_offer();
                    check_offer(tab_exp[i], tab_ferr[i], tab_ovr[i]);
                    ack_offer();
                end
                mode_bad_stop: begin
                    inject_frame(tab_byte[i], tab_div[i], 1'b0);
                    wait_offer();
                    check_offer(tab_exp[i], tab_ferr[i], tab_ovr[i]);
                    ack_offer();
                end
                mode_hold: begin
                    write_byte(tab_byte[i], busy_seen);
                    wait_offer();
                    check_offer(tab_exp[i], tab_ferr[i], tab_ovr[i]);
                end
                default: begin
                    write_byte(tab_byte[i], busy_seen);
                    wait_tx_idle();
                    // rx finishes within a bit time of the stop centre
                    repeat (2 * (32'(tab_div[i]) + 1)) @(negedge clk);
                    if (!rx_req) begin
                        $display("held offer disappeared before it was acknowledged");
                        errors++;
                    end
                    check_offer(tab_exp[i], tab_ferr[i], tab_ovr[i]);
                    ack_offer();
                    if (rx_req) begin
                        $display("a byte sent during a held offer was delivered");
                        errors++;
                    end
                end
            endcase
            finish_test($sformatf("entry %0d mode %0d byte 0x%02h div %0d",
                                  i, tab_mode[i], tab_byte[i], tab_div[i]), e0);
        end

        // four queue entries plus one byte in flight
        e0 = errors;
        wait_tx_idle();
        baud_div = 16'd12;
        for (i = 0; i < 6; i++) begin
            rand_state  = next_random(rand_state);
            bp_bytes[i] = rand_state[7:0];
            write_byte(bp_bytes[i], busy_seen);
            if (i < 5 && busy_seen) begin
                $display("write %0d was held back although the queue had room", i);
                errors++;
            end
            if (i == 5 && !busy_seen) begin
                $display("write 5 was acknowledged before tx_busy fell");
                errors++;
            end
        end
        for (i = 0; i < 6; i++) begin
            wait_offer();
            check_offer(bp_bytes[i], 1'b0, 1'b0);
            ack_offer();
        end
        finish_test("back-pressure and ordering", e0);

        $display("summary: %0d tests, %0d passed, %0d failed, %0d errors",
                 tests_run, tests_run - tests_failed, tests_failed, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// ==== hw/uart_core.sv ====
`timescale 1ns/10ps

module uart_core #(
    parameter int tx_queue_depth = uart_pkg::tx_queue_depth_default
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic [uart_pkg::baud_w-1:0] baud_div,
    // host write side
    input  logic                        wr_req,
    input  logic [uart_pkg::data_w-1:0] wr_data,
    output logic                        wr_ack,
    // host read side
    input  logic                        rx_pin,
    output logic                        rx_req,
    output logic [uart_pkg::data_w-1:0] rx_data,
    output logic                        rx_frame_err,
    output logic                        rx_overrun,
    input  logic                        rx_ack,
    // serial line out
    output logic                        tx_pin,
    output logic                        tx_busy
);

    logic                        q_valid;
    logic [uart_pkg::data_w-1:0] q_data;
    logic                        q_pop;

    uart_tx_queue #(
        .depth   (tx_queue_depth)
    ) tx_queue_inst (
        .clk     (clk),
        .rst_n   (rst_n),
        .wr_req  (wr_req),
        .wr_data (wr_data),
        .wr_ack  (wr_ack),
        .q_valid (q_valid),
        .q_data  (q_data),
        .q_pop   (q_pop)
    );

    uart_tx tx_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .baud_div (baud_div),
        .q_valid  (q_valid),
        .q_data   (q_data),
        .q_pop    (q_pop),
        .tx_pin   (tx_pin),
        .tx_busy  (tx_busy)
    );

    uart_rx rx_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .baud_div     (baud_div),
        .rx_pin       (rx_pin),
        .rx_req       (rx_req),
        .rx_data      (rx_data),
        .rx_frame_err (rx_frame_err),
        .rx_overrun   (rx_overrun),
        .rx_ack       (rx_ack)
    );

endmodule

// ==== hw/uart_rx.sv ====
`timescale 1ns/10ps

module uart_rx (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic [uart_pkg::baud_w-1:0] baud_div,
    input  logic                        rx_pin,
    output logic                        rx_req,
    output logic [uart_pkg::data_w-1:0] rx_data,
    output logic                        rx_frame_err,
    output logic                        rx_overrun,
    input  logic                        rx_ack
);

    localparam int idx_w = $clog2(uart_pkg::data_w);

    logic                        rx_meta;
    logic                        rx_sync;
    logic                        rx_last;    // previous synced level
    logic                        fall;
    uart_pkg::frame_state_t      state;
    logic [uart_pkg::baud_w-1:0] bit_timer;
    logic [uart_pkg::baud_w-1:0] baud_q;
    logic [idx_w-1:0]            bit_idx;
    logic [uart_pkg::data_w-1:0] shift_q;   // lsb arrives first
    logic                        ovr_pending;
    logic                        port_free;

    // two-flop synchronizer plus one stage for edge detection
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
            rx_last <= 1'b1;
        end else begin
            rx_meta <= rx_pin;
            rx_sync <= rx_meta;
            rx_last <= rx_sync;
        end
    end

    assign fall      = rx_last && !rx_sync;
    assign port_free = !rx_req && !rx_ack;  // previous offer fully retired

    always_ff @(posedge clk) begin
        if (state == uart_pkg::idle && fall) begin
            baud_q <= baud_div;
        end
        if (state == uart_pkg::data_bits && bit_timer == '0) begin
            shift_q <= {rx_sync, shift_q[uart_pkg::data_w-1:1]};
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= uart_pkg::idle;
            bit_timer <= '0;
            bit_idx   <= '0;
        end else begin
            case (state)
                uart_pkg::idle: begin
                    if (fall) begin
                        bit_timer <= baud_div >> 1; // half a bit to the centre
                        state     <= uart_pkg::start_bit;
                    end
                end

                uart_pkg::start_bit: begin
                    if (bit_timer != '0) begin
                        bit_timer <= bit_timer - 1'b1;
                    end else if (rx_sync) begin
                        state <= uart_pkg::idle; // glitch, not a start bit
                    end else begin
                        bit_timer <= baud_q;
                        bit_idx   <= '0;
                        state     <= uart_pkg::data_bits;
                    end
                end

                uart_pkg::data_bits: begin
                    if (bit_timer == '0) begin
                        bit_timer <= baud_q;
                        bit_idx   <= bit_idx + 1'b1;
                        if (bit_idx == idx_w'(uart_pkg::data_w - 1)) begin
                            state <= uart_pkg::stop_bit;
                        end
                    end else begin
                        bit_timer <= bit_timer - 1'b1;
                    end
                end

                uart_pkg::stop_bit: begin
                    if (bit_timer == '0) begin
                        state <= uart_pkg::idle; // resync on next falling edge
                    end else begin
                        bit_timer <= bit_timer - 1'b1;
                    end
                end

                default: state <= uart_pkg::idle;
            endcase
        end
    end

    // output side of the four-phase port
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rx_req       <= 1'b0;
            rx_frame_err <= 1'b0;
            rx_overrun   <= 1'b0;
            ovr_pending  <= 1'b0;
        end else begin
            if (rx_req && rx_ack) begin
                rx_req       <= 1'b0;
                rx_frame_err <= 1'b0;
                rx_overrun   <= 1'b0;   // reported once, now consumed
            end
            if (state == uart_pkg::stop_bit && bit_timer == '0) begin
                if (port_free) begin
                    rx_data      <= shift_q;
                    rx_frame_err <= !rx_sync;   // stop bit must be high
                    rx_overrun   <= ovr_pending;
                    rx_req       <= 1'b1;
                    ovr_pending  <= 1'b0;
                end else begin
                    ovr_pending <= 1'b1;        // byte dropped
                end
            end
        end
    end

    rx_data_held: assert property (
        @(posedge clk) disable iff (!rst_n)
        rx_req |=> (!rx_req || $stable(rx_data))
    ) else $error("rx_data changed while rx_req high");

endmodule

// ==== hw/uart_tx.sv ====
`timescale 1ns/10ps

module uart_tx (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic [uart_pkg::baud_w-1:0] baud_div,
    input  logic                        q_valid,
    input  logic [uart_pkg::data_w-1:0] q_data,
    output logic                        q_pop,
    output logic                        tx_pin,
    output logic                        tx_busy
);

    localparam int idx_w = $clog2(uart_pkg::data_w);

    uart_pkg::frame_state_t      state;
    logic [uart_pkg::baud_w-1:0] bit_timer;  // counts baud_q down to zero
    logic [uart_pkg::baud_w-1:0] baud_q;     // divider frozen for the frame
    logic [idx_w-1:0]            bit_idx;
    logic [uart_pkg::data_w-1:0] data_q;

    // take the head byte as soon as the line is free
    assign q_pop   = (state == uart_pkg::idle) && q_valid;
    assign tx_busy = (state != uart_pkg::idle);

    always_ff @(posedge clk) begin
        if (q_pop) begin
            data_q <= q_data;
            baud_q <= baud_div;               // sampled once per frame
        end
    end

    // tx_pin changes on the same edge as the state so each bit is
    // exactly baud_q + 1 cycles wide
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= uart_pkg::idle;
            tx_pin    <= 1'b1;
            bit_timer <= '0;
            bit_idx   <= '0;
        end else begin
            case (state)
                uart_pkg::idle: begin
                    tx_pin <= 1'b1;            // line idles high
                    if (q_pop) begin
                        tx_pin    <= 1'b0;     // start bit begins
                        bit_timer <= baud_div;
                        bit_idx   <= '0;
                        state     <= uart_pkg::start_bit;
                    end
                end

                uart_pkg::start_bit: begin
                    if (bit_timer == '0) begin
                        tx_pin    <= data_q[0];
                        bit_timer <= baud_q;
                        state     <= uart_pkg::data_bits;
                    end else begin
                        bit_timer <= bit_timer - 1'b1;
                    end
                end

                uart_pkg::data_bits: begin
                    if (bit_timer == '0) begin
                        bit_timer <= baud_q;
                        if (bit_idx == idx_w'(uart_pkg::data_w - 1)) begin
                            tx_pin <= 1'b1;    // stop bit
                            state  <= uart_pkg::stop_bit;
                        end else begin
                            tx_pin  <= data_q[bit_idx + 1'b1];
                            bit_idx <= bit_idx + 1'b1;
                        end
                    end else begin
                        bit_timer <= bit_timer - 1'b1;
                    end
                end

                uart_pkg::stop_bit: begin
                    if (bit_timer == '0) begin
                        state <= uart_pkg::idle; // at least one idle cycle follows
                    end else begin
                        bit_timer <= bit_timer - 1'b1;
                    end
                end

                default: state <= uart_pkg::idle;
            endcase
        end
    end

    // the line must rest high between frames
    idle_line_high: assert property (
        @(posedge clk) disable iff (!rst_n)
        (state == uart_pkg::idle) |-> tx_pin
    ) else $error("tx_pin low while transmitter idle");

endmodule

// ==== hw/uart_tx_queue.sv ====
`timescale 1ns/10ps

module uart_tx_queue #(
    parameter int depth = 4
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        wr_req,
    input  logic [uart_pkg::data_w-1:0] wr_data,
    output logic                        wr_ack,
    output logic                        q_valid,
    output logic [uart_pkg::data_w-1:0] q_data,
    input  logic                        q_pop
);

    localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
    localparam int cnt_w = $clog2(depth + 1);

    logic [uart_pkg::data_w-1:0] mem [depth];  // payload storage, no reset
    logic [ptr_w-1:0]            wr_ptr;
    logic [ptr_w-1:0]            rd_ptr;
    logic [cnt_w-1:0]            count;
    logic                        full;
    logic                        push;
    logic                        pop;

    assign full    = (count == cnt_w'(depth));
    assign q_valid = (count != '0);
    assign q_data  = mem[rd_ptr];              // head entry, fall-through

    // a write is taken only in the request phase and only with room left
    assign push = wr_req && !wr_ack && !full;
    assign pop  = q_pop && q_valid;

    // wr_ack itself is the handshake state
    // low: waiting for a request, high: waiting for the request to fall
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ack <= 1'b0;
        end else if (!wr_ack) begin
            if (push) begin
                wr_ack <= 1'b1;                // byte stored, acknowledge
            end
        end else if (!wr_req) begin
            wr_ack <= 1'b0;                    // return to zero
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;       // both or neither
            endcase
        end
    end

    // the transmitter must never pop an empty queue
    pop_only_when_valid: assert property (
        @(posedge clk) disable iff (!rst_n)
        q_pop |-> q_valid
    ) else $error("q_pop while queue empty");

    // host keeps the byte steady until the queue has taken it
    wr_data_held: assert property (
        @(posedge clk) disable iff (!rst_n)
        (wr_req && !wr_ack) |=> (wr_ack || !wr_req || $stable(wr_data))
    ) else $error("wr_data changed during write request");

endmodule

// ==== hw/uart_pkg.sv ====
package uart_pkg;

    // data bits per frame, no parity
    localparam int data_w = 8;

    // run-time baud divider width, one bit lasts baud_div + 1 cycles
    localparam int baud_w = 16;

    // default entry count of the transmit FIFO
    localparam int tx_queue_depth_default = 4;

    // frame sequencing shared by the serializer and deserializer
    typedef enum logic [1:0] {
        idle      = 2'd0,  // line high, waiting for work
        start_bit = 2'd1,  // low start bit
        data_bits = 2'd2,  // eight data bits, lsb first
        stop_bit  = 2'd3   // high stop bit
    } frame_state_t;

endpackage
